/* rtl/bgpu_pkg.sv */
// ####################
// BGPU SoC shared sizes, widths and types
// Used by the dispatcher, the completion arbiter and the debug memory
// ####################

package bgpu_pkg;

    // ####################
    // Sizes and widths

    // Number of compute clusters outside the design
    localparam int NumClusters   = 4;
    // Program counter width
    localparam int PcWidth       = 16;
    // Data pointer and debug address width
    localparam int AddressWidth  = 32;
    // Thread block index inside a thread group
    localparam int TblockIdxBits = 8;
    // Thread group identifier
    localparam int TgroupIdBits  = 8;

    // Debug bus data width
    localparam int DbgWidth       = 32;
    // Debug scratch memory depth in words
    localparam int DbgMemWords    = 64;
    // Word index bits, taken from address bits 7 to 2
    localparam int DbgWordIdxBits = 6;

    // ####################
    // Types

    typedef logic [PcWidth-1:0]       pc_t;
    typedef logic [AddressWidth-1:0]  addr_t;
    typedef logic [TblockIdxBits-1:0] tblock_idx_t;
    typedef logic [TgroupIdBits-1:0]  tgroup_id_t;
    typedef logic [DbgWidth-1:0]      dbg_data_t;
    // One byte select per debug data byte
    typedef logic [DbgWidth/8-1:0]    dbg_sel_t;
    // One bit per compute cluster
    typedef logic [NumClusters-1:0]   cluster_mask_t;

    // Value returned for a word that was never written
    localparam dbg_data_t DbgUninitWord = '1;

    // Warp allocation command, shared by all clusters
    typedef struct packed {
        pc_t         pc;
        addr_t       dp_addr;
        tblock_idx_t tblock_idx;
        tgroup_id_t  tgroup_id;
    } alloc_cmd_t;

endpackage : bgpu_pkg

/* rtl/dbg_wb_if.sv */
// ####################
// Wishbone classic debug bus
// ####################

interface dbg_wb_if import bgpu_pkg::*; ();

    // Cycle and strobe, both high for an access
    logic      cyc;
    logic      stb;
    logic      we;
    addr_t     adr;
    dbg_data_t dat_w;
    dbg_sel_t  sel;
    // Slave response, ack is a single cycle pulse
    dbg_data_t dat_r;
    logic      ack;

    // Master holds adr, we, dat_w and sel until ack
    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface : dbg_wb_if

/* rtl/warp_dispatcher.sv */
// ####################
// Warp dispatcher
// Sends each accepted allocation to the lowest-numbered free cluster
// ####################

module warp_dispatcher import bgpu_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,

    // Host allocation request
    input  logic          alloc_valid_i,
    input  alloc_cmd_t    alloc_cmd_i,
    output logic          warp_free_o,

    // Cluster side
    input  cluster_mask_t cc_warp_free_i,
    output cluster_mask_t cc_allocate_o,
    output alloc_cmd_t    cc_cmd_o
);

    // ####################
    // Signals

    // Registered one-hot select, high for one cycle per allocation
    cluster_mask_t alloc_q;
    // Registered command, shared by all clusters
    alloc_cmd_t    cmd_q;

    // Free clusters not being allocated to this cycle
    cluster_mask_t avail;
    // Lowest available cluster, one-hot
    cluster_mask_t sel;
    logic          sel_found;
    logic          accept;

    // ####################
    // Cluster selection

    // The cluster allocated to last cycle may still report free
    assign avail = cc_warp_free_i & ~alloc_q;

    assign warp_free_o = |avail;

    // Pick the first free cluster, lowest index wins
    always_comb begin : pick_first_free
        sel       = '0;
        sel_found = 1'b0;
        for (int unsigned i = 0; i < NumClusters; i++) begin
            if (!sel_found && avail[i]) begin
                sel[i]    = 1'b1;
                sel_found = 1'b1;
            end
        end
    end : pick_first_free

    // Handshake with the host
    assign accept = alloc_valid_i & warp_free_o;

    // ####################
    // Allocation registers

    // Select pulse, cleared whenever nothing is accepted
    always_ff @(posedge clk_i) begin : alloc_sel_reg
        if (!rst_n_i) begin
            alloc_q <= '0;
        end else if (accept) begin
            alloc_q <= sel;
        end else begin
            alloc_q <= '0;
        end
    end : alloc_sel_reg

    // Command payload, only loaded on acceptance
    always_ff @(posedge clk_i) begin : alloc_cmd_reg
        if (accept) begin
            cmd_q <= alloc_cmd_i;
        end
    end : alloc_cmd_reg

    // Outputs toward the clusters
    assign cc_allocate_o = alloc_q;
    assign cc_cmd_o      = cmd_q;

endmodule : warp_dispatcher

/* rtl/tblock_done_arbiter.sv */
// ####################
// Thread block completion arbiter
// Round-robin merge of per-cluster done reports into one stream
// ####################

module tblock_done_arbiter import bgpu_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Per-cluster done reports
    input  cluster_mask_t                  cc_done_i,
    input  tgroup_id_t [NumClusters-1:0]   cc_done_id_i,
    output cluster_mask_t                  cc_done_ready_o,

    // Merged stream
    output logic                           done_o,
    output tgroup_id_t                     done_id_o,
    input  logic                           done_ready_i
);

    typedef logic [$clog2(NumClusters)-1:0] cluster_idx_t;

    // Priority pointer, first cluster looked at
    cluster_idx_t ptr_q;
    // Grant held while the output stalls
    logic         lock_q;
    cluster_idx_t lock_idx_q;

    cluster_idx_t rr_idx;
    logic         rr_found;
    cluster_idx_t gnt_idx;

    // ####################
    // Round-robin pick

    always_comb begin : rr_pick
        int unsigned idx;
        rr_idx   = ptr_q;
        rr_found = 1'b0;
        // Walk from the pointer, wrapping past the last cluster
        for (int unsigned i = 0; i < NumClusters; i++) begin
            idx = (ptr_q + i) % NumClusters;
            if (!rr_found && cc_done_i[idx]) begin
                rr_idx   = cluster_idx_t'(idx);
                rr_found = 1'b1;
            end
        end
    end : rr_pick

    // Stalled grant wins over a fresh pick
    assign gnt_idx = lock_q ? lock_idx_q : rr_idx;

    // With no request the pick rests on an idle cluster, so done_o is low
    assign done_o    = cc_done_i[gnt_idx];
    assign done_id_o = cc_done_id_i[gnt_idx];

    // Only the granted cluster sees ready
    always_comb begin : ready_fanout
        cc_done_ready_o          = '0;
        cc_done_ready_o[gnt_idx] = done_o & done_ready_i;
    end : ready_fanout

    // ####################
    // Pointer and lock

    always_ff @(posedge clk_i) begin : rr_state
        if (!rst_n_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= done_o & ~done_ready_i;
            lock_idx_q <= gnt_idx;
            // After a transfer the next cluster gets first look
            if (done_o && done_ready_i) begin
                ptr_q <= (gnt_idx == cluster_idx_t'(NumClusters - 1)) ? '0 : gnt_idx + 1'b1;
            end
        end
    end : rr_state

endmodule : tblock_done_arbiter

/* rtl/dbg_mem.sv */
// ####################
// Debug scratch memory on a Wishbone classic slave port
// Unwritten and out-of-range words read as all ones
// ####################

module dbg_mem import bgpu_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    dbg_wb_if.slave wb
);

    // ####################
    // Storage

    dbg_data_t              mem_q [DbgMemWords];
    // One written flag per word
    logic [DbgMemWords-1:0] written_q;

    // Response registers
    logic      ack_q;
    dbg_data_t rdata_q;

    // ####################
    // Access decode

    logic                      req;
    logic                      in_range;
    logic                      wr_en;
    logic [DbgWordIdxBits-1:0] word_idx;
    dbg_data_t                 cur_word;
    dbg_data_t                 wr_word;

    // New access, ack_q blocks a second ack for the same strobe
    assign req = wb.cyc & wb.stb & ~ack_q;

    // Word index from address bits 7 to 2
    assign word_idx = wb.adr[DbgWordIdxBits+1:2];

    // Any set bit above the word index is outside the memory
    assign in_range = ~|wb.adr[AddressWidth-1:DbgWordIdxBits+2];

    // Current content as seen by the bus
    assign cur_word = (in_range && written_q[word_idx]) ? mem_q[word_idx] : DbgUninitWord;

    // Byte merge, unselected bytes keep the current content
    always_comb begin : byte_merge
        for (int unsigned b = 0; b < DbgWidth / 8; b++) begin
            if (wb.sel[b]) begin
                wr_word[8*b +: 8] = wb.dat_w[8*b +: 8];
            end else begin
                wr_word[8*b +: 8] = cur_word[8*b +: 8];
            end
        end
    end : byte_merge

    // Out-of-range writes are acknowledged but dropped
    assign wr_en = req & wb.we & in_range;

    // ####################
    // Control state

    always_ff @(posedge clk_i) begin : ctrl_regs
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            written_q <= '0;
        end else begin
            // Ack one cycle after the strobe, for one cycle
            ack_q <= req;
            if (wr_en) begin
                written_q[word_idx] <= 1'b1;
            end
        end
    end : ctrl_regs

    // ####################
    // Data path

    always_ff @(posedge clk_i) begin : data_regs
        if (wr_en) begin
            mem_q[word_idx] <= wr_word;
        end
        // Read data lines up with ack
        if (req && !wb.we) begin
            rdata_q <= cur_word;
        end
    end : data_regs

    assign wb.ack   = ack_q;
    assign wb.dat_r = rdata_q;

endmodule : dbg_mem

/* rtl/bgpu_soc.sv */
// ####################
// BGPU SoC top level
// Warp dispatch, thread block completion and debug scratch memory
// ####################

module bgpu_soc import bgpu_pkg::*; (
    // Clock and reset
    input  logic                         ext_clk_i,
    input  logic                         rst_n_i,

    // Debug bus, Wishbone classic
    input  logic                         dbg_cyc_i,
    input  logic                         dbg_stb_i,
    input  logic                         dbg_we_i,
    input  addr_t                        dbg_adr_i,
    input  dbg_data_t                    dbg_dat_i,
    input  dbg_sel_t                     dbg_sel_i,
    output dbg_data_t                    dbg_dat_o,
    output logic                         dbg_ack_o,

    // Host allocation request
    input  logic                         alloc_valid_i,
    input  pc_t                          alloc_pc_i,
    input  addr_t                        alloc_dp_addr_i,
    input  tblock_idx_t                  alloc_tblock_idx_i,
    input  tgroup_id_t                   alloc_tgroup_id_i,
    output logic                         warp_free_o,

    // Cluster allocation side
    input  cluster_mask_t                cc_warp_free_i,
    output cluster_mask_t                cc_allocate_o,
    output pc_t                          cc_pc_o,
    output addr_t                        cc_dp_addr_o,
    output tblock_idx_t                  cc_tblock_idx_o,
    output tgroup_id_t                   cc_tgroup_id_o,

    // Cluster completion side
    input  cluster_mask_t                cc_done_i,
    input  tgroup_id_t [NumClusters-1:0] cc_done_id_i,
    output cluster_mask_t                cc_done_ready_o,

    // Merged completion stream
    output logic                         tblock_done_o,
    output tgroup_id_t                   tblock_done_id_o,
    input  logic                         tblock_done_ready_i
);

    // ####################
    // Signals

    // Allocation command in and out of the dispatcher
    alloc_cmd_t alloc_cmd;
    alloc_cmd_t cc_cmd;

    // Debug bus toward the scratch memory
    dbg_wb_if dbg_wb ();

    // ####################
    // Warp allocation

    // Pack the host fields
    assign alloc_cmd.pc         = alloc_pc_i;
    assign alloc_cmd.dp_addr    = alloc_dp_addr_i;
    assign alloc_cmd.tblock_idx = alloc_tblock_idx_i;
    assign alloc_cmd.tgroup_id  = alloc_tgroup_id_i;

    warp_dispatcher i_warp_dispatcher (
        .clk_i         ( ext_clk_i      ),
        .rst_n_i       ( rst_n_i        ),
        .alloc_valid_i ( alloc_valid_i  ),
        .alloc_cmd_i   ( alloc_cmd      ),
        .warp_free_o   ( warp_free_o    ),
        .cc_warp_free_i( cc_warp_free_i ),
        .cc_allocate_o ( cc_allocate_o  ),
        .cc_cmd_o      ( cc_cmd         )
    );

    // Command fields go to every cluster, the one-hot select picks one
    assign cc_pc_o         = cc_cmd.pc;
    assign cc_dp_addr_o    = cc_cmd.dp_addr;
    assign cc_tblock_idx_o = cc_cmd.tblock_idx;
    assign cc_tgroup_id_o  = cc_cmd.tgroup_id;

    // ####################
    // Thread block completion

    tblock_done_arbiter i_tblock_done_arbiter (
        .clk_i          ( ext_clk_i           ),
        .rst_n_i        ( rst_n_i             ),
        .cc_done_i      ( cc_done_i           ),
        .cc_done_id_i   ( cc_done_id_i        ),
        .cc_done_ready_o( cc_done_ready_o     ),
        .done_o         ( tblock_done_o       ),
        .done_id_o      ( tblock_done_id_o    ),
        .done_ready_i   ( tblock_done_ready_i )
    );

    // ####################
    // Debug memory

    // Top ports act as the bus master
    assign dbg_wb.cyc   = dbg_cyc_i;
    assign dbg_wb.stb   = dbg_stb_i;
    assign dbg_wb.we    = dbg_we_i;
    assign dbg_wb.adr   = dbg_adr_i;
    assign dbg_wb.dat_w = dbg_dat_i;
    assign dbg_wb.sel   = dbg_sel_i;

    dbg_mem i_dbg_mem (
        .clk_i  ( ext_clk_i ),
        .rst_n_i( rst_n_i   ),
        .wb     ( dbg_wb    )
    );

    // Slave response back to the ports
    assign dbg_dat_o = dbg_wb.dat_r;
    assign dbg_ack_o = dbg_wb.ack;

endmodule : bgpu_soc

/* tests/bgpu_soc_chk.sv */
// ####################
// Handshake assertions for the BGPU SoC top level
// ####################

module bgpu_soc_chk import bgpu_pkg::*; (
    input logic          clk_i,
    input logic          rst_n_i,
    input logic          dbg_ack_i,
    input cluster_mask_t cc_allocate_i,
    input logic          tblock_done_i,
    input tgroup_id_t    tblock_done_id_i,
    input logic          tblock_done_ready_i
);

    // Failed assertions so far
    int fail_count = 0;

    // Wishbone ack is a single cycle pulse
    ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dbg_ack_i |=> !dbg_ack_i)
    else begin
        fail_count++;
        $error("debug ack held for more than one cycle");
    end

    // At most one cluster per allocation
    alloc_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(cc_allocate_i))
    else begin
        fail_count++;
        $error("allocation select has more than one bit set");
    end

    // Stalled completion keeps valid and id
    done_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tblock_done_i && !tblock_done_ready_i |=> tblock_done_i && $stable(tblock_done_id_i))
    else begin
        fail_count++;
        $error("completion id changed or valid dropped while stalled");
    end

endmodule : bgpu_soc_chk

bind bgpu_soc bgpu_soc_chk i_bgpu_soc_chk (
    .clk_i              ( ext_clk_i           ),
    .rst_n_i            ( rst_n_i             ),
    .dbg_ack_i          ( dbg_ack_o           ),
    .cc_allocate_i      ( cc_allocate_o       ),
    .tblock_done_i      ( tblock_done_o       ),
    .tblock_done_id_i   ( tblock_done_id_o    ),
    .tblock_done_ready_i( tblock_done_ready_i )
);

/* tests/bgpu_soc_tb.sv */
// ####################
// BGPU SoC testbench
// Table of debug, allocation and completion rows applied in order
// ####################

module bgpu_soc_tb import bgpu_pkg::*; ();

    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 4;
    // Wait before sampling combinational outputs
    localparam int Settle      = 5;
    localparam int NumRows     = 25;
    localparam int MaxCycles   = NumRows * 20 + 10;
    localparam logic [31:0] LfsrSeed = 32'h80c5;
    // Maximal length Galois taps
    localparam logic [31:0] LfsrTaps = 32'hb4bc_d35c;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_ALLOC, OP_DONE} op_e;

    // Mask is the free mask or the done mask
    // Data holds the four done ids on completion rows
    typedef struct {
        string         name;
        op_e           op;
        logic          rnd;
        addr_t         adr;
        logic [31:0]   data;
        dbg_sel_t      sel;
        cluster_mask_t mask;
        logic          ready;
        logic [31:0]   exp_data;
        cluster_mask_t exp_mask;
        logic          exp_bit;
    } row_t;

    // name, op, rnd, adr, data, sel, mask, ready, exp_data, exp_mask, exp_bit
    row_t rows [NumRows] = '{
        '{"wr full", OP_WR, 1, 'h10, 0, 'hf, 0, 0, 0, 0, 0},
        '{"rd full", OP_RD, 1, 'h10, 0, 'hf, 0, 0, 0, 0, 0},
        '{"rd unwritten", OP_RD, 0, 'h24, 0, 'hf, 0, 0, 'hffff_ffff, 0, 0},
        '{"wr base", OP_WR, 0, 'h20, 'h1122_3344, 'hf, 0, 0, 0, 0, 0},
        '{"wr bytes 0 2", OP_WR, 0, 'h20, 'haabb_ccdd, 'h5, 0, 0, 0, 0, 0},
        '{"rd merged", OP_RD, 0, 'h20, 0, 'hf, 0, 0, 'h11bb_33dd, 0, 0},
        '{"wr first partial", OP_WR, 0, 'h28, 'h1234_5678, 'h3, 0, 0, 0, 0, 0},
        '{"rd first partial", OP_RD, 0, 'h28, 0, 'hf, 0, 0, 'hffff_5678, 0, 0},
        '{"wr out of range", OP_WR, 0, 'h100, 'h0bad_0bad, 'hf, 0, 0, 0, 0, 0},
        '{"rd out of range", OP_RD, 0, 'h100, 0, 'hf, 0, 0, 'hffff_ffff, 0, 0},
        '{"rd alias word 0", OP_RD, 0, 'h0, 0, 'hf, 0, 0, 'hffff_ffff, 0, 0},
        '{"alloc first free", OP_ALLOC, 1, 0, 0, 0, 'b0110, 0, 0, 'b0010, 1},
        '{"alloc none free", OP_ALLOC, 1, 0, 0, 0, 'b0000, 0, 0, 'b0000, 0},
        '{"alloc b2b first", OP_ALLOC, 1, 0, 0, 0, 'b1010, 0, 0, 'b0010, 1},
        '{"alloc b2b second", OP_ALLOC, 1, 0, 0, 0, 'b1010, 0, 0, 'b1000, 1},
        '{"alloc b2b third", OP_ALLOC, 1, 0, 0, 0, 'b0010, 0, 0, 'b0010, 1},
        '{"alloc masked busy", OP_ALLOC, 1, 0, 0, 0, 'b0010, 0, 0, 'b0000, 0},
        '{"rr from zero", OP_DONE, 0, 0, 'h1312_1110, 0, 'b1010, 1, 'h11, 'b0010, 1},
        '{"rr stall", OP_DONE, 0, 0, 'h1312_1110, 0, 'b1011, 0, 'h13, 'b0000, 1},
        '{"rr stall locked", OP_DONE, 0, 0, 'h1312_1110, 0, 'b1111, 0, 'h13, 'b0000, 1},
        '{"rr release", OP_DONE, 0, 0, 'h1312_1110, 0, 'b1111, 1, 'h13, 'b1000, 1},
        '{"rr wrap", OP_DONE, 0, 0, 'h1312_1110, 0, 'b0111, 1, 'h10, 'b0001, 1},
        '{"rr next", OP_DONE, 0, 0, 'h1312_1110, 0, 'b0110, 1, 'h11, 'b0010, 1},
        '{"rr last", OP_DONE, 0, 0, 'h1312_1110, 0, 'b0100, 1, 'h12, 'b0100, 1},
        '{"rr idle", OP_DONE, 0, 0, 'h1312_1110, 0, 'b0000, 1, 0, 'b0000, 0}
    };

    // DUT signals named as its ports
    logic          ext_clk_i, rst_n_i;
    logic          dbg_cyc_i, dbg_stb_i, dbg_we_i, dbg_ack_o;
    addr_t         dbg_adr_i, alloc_dp_addr_i, cc_dp_addr_o;
    dbg_data_t     dbg_dat_i, dbg_dat_o;
    dbg_sel_t      dbg_sel_i;
    logic          alloc_valid_i, warp_free_o, tblock_done_o, tblock_done_ready_i;
    pc_t           alloc_pc_i, cc_pc_o;
    tblock_idx_t   alloc_tblock_idx_i, cc_tblock_idx_o;
    tgroup_id_t    alloc_tgroup_id_i, cc_tgroup_id_o, tblock_done_id_o;
    cluster_mask_t cc_warp_free_i, cc_allocate_o, cc_done_i, cc_done_ready_o;
    tgroup_id_t [NumClusters-1:0] cc_done_id_i;

    logic [31:0]   lfsr_q;
    // Last random write data for the next random read
    dbg_data_t     rnd_word;

    bgpu_soc DUT (.*);

    // Galois LFSR stepped once per bit taken
    function automatic logic [63:0] take_bits(input int unsigned n);
        logic [63:0] bits;
        bits = '0;
        for (int unsigned i = 0; i < n; i++) begin
            bits   = {bits[62:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LfsrTaps) : (lfsr_q >> 1);
        end
        return bits;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
        if (act_val !== exp_val) begin
            $display("error: %s expected %h actual %h", name, exp_val, act_val);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // One Wishbone classic access followed by one idle cycle
    task automatic debug_access(input row_t row);
        int unsigned wait_cycles;
        dbg_cyc_i = 1'b1;
        dbg_stb_i = 1'b1;
        dbg_we_i  = (row.op == OP_WR);
        dbg_adr_i = row.adr;
        dbg_dat_i = row.data;
        dbg_sel_i = row.sel;
        if (row.op == OP_WR && row.rnd) begin
            dbg_dat_i = dbg_data_t'(take_bits(32));
            rnd_word  = dbg_dat_i;
        end
        // No ack in the cycle the strobe rises
        #Settle;
        compare_value({row.name, " ack early"}, 64'(0), 64'(dbg_ack_o));
        wait_cycles = 0;
        do begin
            @(negedge ext_clk_i);
            wait_cycles++;
        end while (!dbg_ack_o);
        compare_value({row.name, " ack delay"}, 64'(1), 64'(wait_cycles));
        if (row.op == OP_RD) begin
            compare_value({row.name, " read data"},
                          64'(row.rnd ? rnd_word : row.exp_data), 64'(dbg_dat_o));
        end
        // Strobe drops in the cycle after ack
        dbg_cyc_i = 1'b0;
        dbg_stb_i = 1'b0;
        dbg_we_i  = 1'b0;
        @(negedge ext_clk_i);
    endtask

    // Request held for one cycle with the select checked one cycle later
    task automatic alloc_request(input row_t row);
        logic [63:0] cmd_sent;
        alloc_valid_i  = 1'b1;
        cc_warp_free_i = row.mask;
        cmd_sent       = row.rnd ? take_bits(64) : 64'(0);
        {alloc_pc_i, alloc_dp_addr_i, alloc_tblock_idx_i, alloc_tgroup_id_i} = cmd_sent;
        #Settle;
        compare_value({row.name, " warp free"}, 64'(row.exp_bit), 64'(warp_free_o));
        @(negedge ext_clk_i);
        compare_value({row.name, " allocate"}, 64'(row.exp_mask), 64'(cc_allocate_o));
        if (row.exp_mask != '0) begin
            compare_value({row.name, " command"}, cmd_sent,
                          {cc_pc_o, cc_dp_addr_o, cc_tblock_idx_o, cc_tgroup_id_o});
        end
        alloc_valid_i = 1'b0;
    endtask

    // Completion is combinational and the pointer moves at the next edge
    task automatic done_report(input row_t row);
        cc_done_i           = row.mask;
        cc_done_id_i        = row.data;
        tblock_done_ready_i = row.ready;
        #Settle;
        compare_value({row.name, " done valid"}, 64'(row.exp_bit), 64'(tblock_done_o));
        compare_value({row.name, " cluster ready"}, 64'(row.exp_mask), 64'(cc_done_ready_o));
        if (row.exp_bit) begin
            compare_value({row.name, " done id"}, 64'(row.exp_data[7:0]),
                          64'(tblock_done_id_o));
        end
        @(negedge ext_clk_i);
    endtask

    initial begin : clock_gen
        ext_clk_i = 1'b0;
        forever begin
            #(ClkPeriod / 2) ext_clk_i = ~ext_clk_i;
        end
    end : clock_gen

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge ext_clk_i);
            cycles++;
            if (cycles >= MaxCycles) begin
                $display("CHECKS FAILED");
                $fatal(1, "run timed out after %0d cycles", cycles);
            end
        end
    end : watchdog

    initial begin : run_rows
        // All inputs idle while reset is held
        rst_n_i = 1'b0;
        {dbg_cyc_i, dbg_stb_i, dbg_we_i, dbg_adr_i, dbg_dat_i, dbg_sel_i} = '0;
        {alloc_valid_i, alloc_pc_i, alloc_dp_addr_i, alloc_tblock_idx_i, alloc_tgroup_id_i} = '0;
        {cc_warp_free_i, cc_done_i, cc_done_id_i, tblock_done_ready_i} = '0;
        lfsr_q   = LfsrSeed;
        rnd_word = '0;
        repeat (ResetCycles) @(negedge ext_clk_i);
        rst_n_i = 1'b1;
        // Every row starts on a falling edge
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WR, OP_RD: debug_access(rows[i]);
                OP_ALLOC:     alloc_request(rows[i]);
                default:      done_report(rows[i]);
            endcase
        end
        if (DUT.i_bgpu_soc_chk.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "%0d handshake assertions failed", DUT.i_bgpu_soc_chk.fail_count);
        end
    end : run_rows

endmodule : bgpu_soc_tb

/* Bender.yml */
package:
  name: bgpu_soc

sources:
  - rtl/bgpu_pkg.sv
  - rtl/dbg_wb_if.sv
  - rtl/warp_dispatcher.sv
  - rtl/tblock_done_arbiter.sv
  - rtl/dbg_mem.sv
  - rtl/bgpu_soc.sv
  - target: test
    files:
      - tests/bgpu_soc_chk.sv
      - tests/bgpu_soc_tb.sv

/* bgpu_soc.f */
rtl/bgpu_pkg.sv
rtl/dbg_wb_if.sv
rtl/warp_dispatcher.sv
rtl/tblock_done_arbiter.sv
rtl/dbg_mem.sv
rtl/bgpu_soc.sv
tests/bgpu_soc_chk.sv
tests/bgpu_soc_tb.sv
